// File: design/bus_cfg_pkg.sv
/*
 * Bus geometry for the shared instruction/data Wishbone path.
 * Widths of the classic bus, the requester port numbers and
 * the arbitration start point after reset.
 */
package bus_cfg_pkg;

    // Classic Wishbone, word addressed
    localparam int ADR_W = 30;
    localparam int DAT_W = 32;
    localparam int SEL_W = DAT_W / 8;

    // Instruction and data requesters
    localparam int NUM_PORTS = 2;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

    localparam port_id_t PORT_I = 1'b0;
    localparam port_id_t PORT_D = 1'b1;

    // Last grant seen out of reset, so the instruction port goes first
    localparam port_id_t LAST_GRANT_RST = PORT_D;

endpackage

// File: design/litex_bus_wrapper.sv
/*
 * Combined instruction/data bus wrapper.
 * Two requester slots share one classic Wishbone master and
 * get their responses back with a one-cycle done.
 */
`timescale 1ns/1ps

module litex_bus_wrapper
    import bus_cfg_pkg::*;
    import wb_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  logic  ireq_strobe,
    input  ireq_t ireq,
    input  logic  dreq_strobe,
    input  dreq_t dreq,

    output wb_m_t wb_m,
    input  wb_s_t wb_s,

    output logic  idone,
    output logic  ddone,
    output resp_t iresp,
    output resp_t dresp
);

    logic     ipending;
    logic     dpending;
    ireq_t    ireq_held;
    dreq_t    dreq_held;
    logic     itake;
    logic     dtake;
    logic     end_strobe;
    port_id_t owner;

    req_slot #(.req_t(ireq_t)) islot (
        .clk     (clk),
        .arst_n  (arst_n),
        .strobe  (ireq_strobe),
        .req_in  (ireq),
        .take    (itake),
        .pending (ipending),
        .req_out (ireq_held)
    );

    req_slot #(.req_t(dreq_t)) dslot (
        .clk     (clk),
        .arst_n  (arst_n),
        .strobe  (dreq_strobe),
        .req_in  (dreq),
        .take    (dtake),
        .pending (dpending),
        .req_out (dreq_held)
    );

    wb_master_ctrl ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .ipending   (ipending),
        .ireq       (ireq_held),
        .dpending   (dpending),
        .dreq       (dreq_held),
        .wb_m       (wb_m),
        .wb_s       (wb_s),
        .itake      (itake),
        .dtake      (dtake),
        .end_strobe (end_strobe),
        .owner      (owner)
    );

    resp_return resp (
        .clk        (clk),
        .arst_n     (arst_n),
        .end_strobe (end_strobe),
        .owner      (owner),
        .wb_s       (wb_s),
        .idone      (idone),
        .ddone      (ddone),
        .iresp      (iresp),
        .dresp      (dresp)
    );

endmodule

// File: design/req_slot.sv
/*
 * Request holding slot.
 * Captures one request on its strobe and keeps it pending
 * until the bus controller takes it at the end of its cycle.
 */
`timescale 1ns/1ps

module req_slot
    import wb_types_pkg::*;
#(
    parameter type req_t = ireq_t
) (
    input  logic clk,
    input  logic arst_n,

    input  logic strobe,
    input  req_t req_in,

    input  logic take,
    output logic pending,
    output req_t req_out
);

    logic accept;

    // A second strobe while still pending breaks the requester rule
    assign accept = strobe && !pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end
    end

    // Payload only, qualified by pending
    always_ff @(posedge clk) begin
        if (accept) begin
            req_out <= req_in;
        end
    end

endmodule

// File: design/resp_return.sv
/*
 * Response return path.
 * Latches read data and error at the end of a bus cycle into
 * the owner's response and raises its done for one cycle.
 */
`timescale 1ns/1ps

module resp_return
    import bus_cfg_pkg::*;
    import wb_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     end_strobe,
    input  port_id_t owner,
    input  wb_s_t    wb_s,

    output logic     idone,
    output logic     ddone,
    output resp_t    iresp,
    output resp_t    dresp
);

    logic iend;
    logic dend;

    assign iend = end_strobe && (owner == PORT_I);
    assign dend = end_strobe && (owner == PORT_D);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idone <= 1'b0;
            ddone <= 1'b0;
        end else begin
            idone <= iend;
            ddone <= dend;
        end
    end

    // Held until the same port finishes again
    always_ff @(posedge clk) begin
        if (iend) begin
            iresp <= '{rdata: wb_s.dat_r, err: wb_s.err};
        end
        if (dend) begin
            dresp <= '{rdata: wb_s.dat_r, err: wb_s.err};
        end
    end

endmodule

// File: design/wb_master_ctrl.sv
/*
 * Shared Wishbone master.
 * Round-robin choice between the instruction and data slots,
 * then one classic single-beat cycle held until ack or err.
 */
`timescale 1ns/1ps

module wb_master_ctrl
    import bus_cfg_pkg::*;
    import wb_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     ipending,
    input  ireq_t    ireq,
    input  logic     dpending,
    input  dreq_t    dreq,

    output wb_m_t    wb_m,
    input  wb_s_t    wb_s,

    output logic     itake,
    output logic     dtake,
    output logic     end_strobe,
    output port_id_t owner
);

    typedef enum logic {
        IDLE,
        ACTIVE
    } state_t;

    state_t           state;
    port_id_t         last_grant;
    port_id_t         pick;
    logic             any_pending;
    logic             grant;
    logic             bus_end;

    logic [ADR_W-1:0] adr_q;
    logic [DAT_W-1:0] dat_q;
    logic [SEL_W-1:0] sel_q;
    logic             we_q;

    assign any_pending = ipending || dpending;
    assign grant       = (state == IDLE) && any_pending;
    assign bus_end     = (state == ACTIVE) && (wb_s.ack || wb_s.err);

    // Both waiting: the port not served last wins
    always_comb begin
        if (ipending && dpending) begin
            pick = (last_grant == PORT_I) ? PORT_D : PORT_I;
        end else if (dpending) begin
            pick = PORT_D;
        end else begin
            pick = PORT_I;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            last_grant <= LAST_GRANT_RST;
        end else begin
            case (state)
                IDLE: begin
                    if (any_pending) begin
                        state      <= ACTIVE;
                        last_grant <= pick;
                    end
                end
                ACTIVE: begin
                    if (bus_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Bus payload loaded at grant, stable for the whole cycle
    always_ff @(posedge clk) begin
        if (grant) begin
            if (pick == PORT_I) begin
                adr_q <= ireq.adr;
                dat_q <= '0;
                sel_q <= '1;
                we_q  <= 1'b0;
            end else begin
                adr_q <= dreq.adr;
                dat_q <= dreq.wdata;
                sel_q <= dreq.sel;
                we_q  <= dreq.we;
            end
        end
    end

    // cyc and stb come straight from the state flop
    assign wb_m = '{
        adr:   adr_q,
        dat_w: dat_q,
        sel:   sel_q,
        cyc:   (state == ACTIVE),
        stb:   (state == ACTIVE),
        we:    we_q
    };

    assign owner      = last_grant;
    assign end_strobe = bus_end;
    assign itake      = bus_end && (last_grant == PORT_I);
    assign dtake      = bus_end && (last_grant == PORT_D);

endmodule

// File: design/wb_types_pkg.sv
/*
 * Transfer types for the shared Wishbone path.
 * Requester payloads, master and slave bus bundles and the
 * response handed back to each requester.
 */
package wb_types_pkg;
    import bus_cfg_pkg::*;

    // Instruction fetch, always a full word read
    typedef struct packed {
        logic [ADR_W-1:0] adr;
    } ireq_t;

    // Data load or store
    typedef struct packed {
        logic [ADR_W-1:0] adr;
        logic             we;
        logic [SEL_W-1:0] sel;
        logic [DAT_W-1:0] wdata;
    } dreq_t;

    // Master outputs
    typedef struct packed {
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat_w;
        logic [SEL_W-1:0] sel;
        logic             cyc;
        logic             stb;
        logic             we;
    } wb_m_t;

    // Slave returns
    typedef struct packed {
        logic [DAT_W-1:0] dat_r;
        logic             ack;
        logic             err;
    } wb_s_t;

    // What a requester gets back with its done pulse
    typedef struct packed {
        logic [DAT_W-1:0] rdata;
        logic             err;
    } resp_t;

endpackage

// File: dv/bus_input.txt
// port we adr sel wdata rdata_exp, all hex; port 0 is instruction, 1 is data
// adr is a word address; rdata_exp is ignored for writes and error responses
0 0 00000100 f 00000000 dead0400
1 1 00000040 3 11223344 00000000
0 0 00000101 f 00000000 dead0404
1 0 00000040 f 00000000 dead3344
0 0 3ffffff0 f 00000000 00000000
1 1 00000040 c aabbccdd 00000000
0 0 00000102 f 00000000 dead0408
1 0 00000040 f 00000000 aabb3344
0 0 00000200 f 00000000 dead0800
1 0 3c000010 f 00000000 00000000
0 0 00000103 f 00000000 dead040c
1 1 3c000010 f 12345678 00000000
0 0 00000fff f 00000000 dead3ffc
1 0 00000041 f 00000000 dead0104
1 1 00000080 1 000000ee 00000000
1 0 00000080 f 00000000 dead02ee
1 1 00000080 f 5eed1234 00000000
1 0 00000080 f 00000000 5eed1234

// File: dv/litex_bus_wrapper_sva.sv
/*
 * Wishbone protocol and done pulse assertions for the bus wrapper.
 */
`timescale 1ns/1ps

module litex_bus_wrapper_sva
    import wb_types_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input wb_m_t wb_m,
    input wb_s_t wb_s,
    input logic  idone,
    input logic  ddone
);

    // Failed assertion count
    int fail_count = 0;

    // Quiet bus and no done while in reset
    assert property (@(posedge clk) !arst_n |-> !wb_m.cyc && !wb_m.stb && !idone && !ddone)
        else begin
            fail_count++;
            $error("bus or done active during reset");
        end

    // Stalled cycle holds its request
    assert property (@(posedge clk) disable iff (!arst_n)
        wb_m.stb && !(wb_s.ack || wb_s.err) |=>
            wb_m.stb && $stable({wb_m.adr, wb_m.dat_w, wb_m.sel, wb_m.we}))
        else begin
            fail_count++;
            $error("master changed while waiting for ack or err");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        wb_m.stb && (wb_s.ack || wb_s.err) |=> !wb_m.stb)
        else begin
            fail_count++;
            $error("stb still high after the response edge");
        end

    assert property (@(posedge clk) disable iff (!arst_n) !(wb_s.ack && wb_s.err))
        else begin
            fail_count++;
            $error("ack and err high together");
        end

    // A done follows only a response edge and lasts one cycle on one port
    assert property (@(posedge clk) disable iff (!arst_n)
        (idone || ddone) |-> !(idone && ddone) && $past(wb_m.stb && (wb_s.ack || wb_s.err)))
        else begin
            fail_count++;
            $error("done pulse without a finished bus cycle");
        end

    assert property (@(posedge clk) disable iff (!arst_n) idone |=> !idone)
        else begin
            fail_count++;
            $error("idone longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (!arst_n) ddone |=> !ddone)
        else begin
            fail_count++;
            $error("ddone longer than one cycle");
        end

endmodule

bind litex_bus_wrapper litex_bus_wrapper_sva bus_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_m   (wb_m),
    .wb_s   (wb_s),
    .idone  (idone),
    .ddone  (ddone)
);

// File: dv/litex_bus_wrapper_tb.sv
/*
 * Testbench for the combined instruction/data bus wrapper.
 * File-driven requesters on both ports, a Wishbone slave with random
 * wait states and a bus monitor that predicts the round-robin grants.
 */
`timescale 1ns/1ps

module litex_bus_wrapper_tb
    import bus_cfg_pkg::*;
    import wb_types_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DLY  = 1;
    localparam int RST_CYCLES = 5;
    localparam int NCOL       = 6;
    localparam int MAX_LINES  = 32;

    logic  clk = 1'b0;
    logic  arst_n;
    logic  ireq_strobe;
    ireq_t ireq;
    logic  dreq_strobe;
    dreq_t dreq;
    wb_m_t wb_m;
    wb_s_t wb_s;
    logic  idone;
    logic  ddone;
    resp_t iresp;
    resp_t dresp;

    // Six words per request in file column order
    logic [31:0]      stim [NCOL*MAX_LINES];
    int               num_lines;
    int               cycles_seen;

    // Sparse slave memory holding written words only
    logic [ADR_W-1:0] mem_adr [$];
    logic [DAT_W-1:0] mem_dat [$];
    logic             busy;
    int               waits;

    // Bus monitor state
    wb_m_t            exp_m [NUM_PORTS];
    logic             outst [NUM_PORTS];
    logic             ipend_prev;
    logic             dpend_prev;
    logic             cyc_prev;
    logic             ended;
    port_id_t         cyc_port;
    port_id_t         last_port;

    litex_bus_wrapper UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic in_err_range(input logic [ADR_W-1:0] adr);
        return adr[ADR_W-1 -: 4] == 4'hF;
    endfunction

    // Unwritten words read back a pattern of their own address
    function automatic logic [DAT_W-1:0] mem_read(input logic [ADR_W-1:0] adr);
        foreach (mem_adr[i]) begin
            if (mem_adr[i] == adr) begin
                return mem_dat[i];
            end
        end
        return {adr, 2'b00} ^ 32'hDEAD_0000;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic got);
        if (got !== exp_v) begin
            fail_now($sformatf("Mismatch at time %0t: %s expected %b, got %b",
                               $time, name, exp_v, got));
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp_r, input resp_t got,
                              input logic check_data);
        resp_t e;
        resp_t g;
        e = exp_r;
        g = got;
        if (!check_data) begin
            e.rdata = '0;
            g.rdata = '0;
        end
        if (g !== e) begin
            fail_now($sformatf("Mismatch at time %0t: %s expected %h, got %h",
                               $time, name, e, g));
        end
    endtask

    task automatic check_wb(input string name, input wb_m_t exp_w, input wb_m_t got);
        wb_m_t e;
        wb_m_t g;
        e = exp_w;
        g = got;
        // Write data is meaningless on a read
        if (!exp_w.we) begin
            e.dat_w = '0;
            g.dat_w = '0;
        end
        if (g !== e) begin
            fail_now($sformatf("Mismatch at time %0t: %s expected %h, got %h",
                               $time, name, e, g));
        end
    endtask

    task automatic respond();
        logic [DAT_W-1:0] word;
        int               idx;
        if (in_err_range(wb_m.adr)) begin
            wb_s.err = 1'b1;
        end else begin
            word = mem_read(wb_m.adr);
            if (wb_m.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (wb_m.sel[b]) begin
                        word[8*b +: 8] = wb_m.dat_w[8*b +: 8];
                    end
                end
                idx = -1;
                foreach (mem_adr[i]) begin
                    if (mem_adr[i] == wb_m.adr) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    mem_adr.push_back(wb_m.adr);
                    mem_dat.push_back(word);
                end else begin
                    mem_dat[idx] = word;
                end
            end
            wb_s.dat_r = word;
            wb_s.ack   = 1'b1;
        end
    endtask

    // Slave with 0 to 3 wait states per cycle that drops its response once sampled
    initial begin
        void'($urandom(64));
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (wb_s.ack || wb_s.err) begin
                wb_s = '0;
                busy = 1'b0;
            end else if (wb_m.cyc && wb_m.stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = $urandom % 4;
                end
                if (waits == 0) begin
                    respond();
                end else begin
                    waits--;
                end
            end
        end
    end

    // Grant prediction uses the pending state seen one negedge earlier
    always @(negedge clk) begin
        if (!arst_n) begin
            check_flag("wb_m.cyc", 1'b0, wb_m.cyc);
            check_flag("wb_m.stb", 1'b0, wb_m.stb);
            check_flag("idone", 1'b0, idone);
            check_flag("ddone", 1'b0, ddone);
        end else begin
            if (wb_m.cyc && !cyc_prev) begin
                if (!ipend_prev && !dpend_prev) begin
                    fail_now("A bus cycle started while no request was pending");
                end
                if (ipend_prev && dpend_prev) begin
                    cyc_port = (last_port == PORT_I) ? PORT_D : PORT_I;
                end else begin
                    cyc_port = dpend_prev ? PORT_D : PORT_I;
                end
                last_port = cyc_port;
                cycles_seen++;
            end
            if (wb_m.cyc) begin
                check_wb("wb_m", exp_m[cyc_port], wb_m);
            end
            ended = cyc_prev && !wb_m.cyc;
            check_flag("idone", ended && (cyc_port == PORT_I), idone);
            check_flag("ddone", ended && (cyc_port == PORT_D), ddone);
            cyc_prev   = wb_m.cyc;
            ipend_prev = outst[PORT_I] && !ireq_strobe && !idone;
            dpend_prev = outst[PORT_D] && !dreq_strobe && !ddone;
        end
    end

    // Bound protocol checker
    always @(negedge clk) begin
        if (UUT.bus_sva.fail_count != 0) begin
            fail_now("A Wishbone protocol assertion in the bound checker failed");
        end
    end

    task automatic run_port(input port_id_t p);
        int               base;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [SEL_W-1:0] sel;
        resp_t            exp_r;
        for (int n = 0; n < num_lines; n++) begin
            base = n * NCOL;
            if (stim[base] != 32'(p)) begin
                continue;
            end
            we  = stim[base+1][0];
            adr = stim[base+2][ADR_W-1:0];
            sel = stim[base+3][SEL_W-1:0];
            @(posedge clk);
            #DRIVE_DLY;
            if (p == PORT_I) begin
                ireq.adr    = adr;
                ireq_strobe = 1'b1;
                exp_m[p]    = '{adr: adr, dat_w: '0, sel: '1, cyc: 1'b1, stb: 1'b1, we: 1'b0};
            end else begin
                dreq        = '{adr: adr, we: we, sel: sel, wdata: stim[base+4]};
                dreq_strobe = 1'b1;
                exp_m[p]    = '{adr: adr, dat_w: stim[base+4], sel: sel,
                                cyc: 1'b1, stb: 1'b1, we: we};
            end
            outst[p] = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            if (p == PORT_I) begin
                ireq_strobe = 1'b0;
            end else begin
                dreq_strobe = 1'b0;
            end
            do begin
                @(negedge clk);
            end while ((p == PORT_I) ? !idone : !ddone);
            exp_r = '{rdata: stim[base+5], err: in_err_range(adr)};
            if (p == PORT_I) begin
                check_resp("iresp", exp_r, iresp, !exp_r.err);
            end else begin
                check_resp("dresp", exp_r, dresp, !exp_r.err && !we);
            end
            outst[p] = 1'b0;
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        ireq_strobe = 1'b0;
        ireq        = '0;
        dreq_strobe = 1'b0;
        dreq        = '0;
        wb_s        = '0;
        busy        = 1'b0;
        waits       = 0;
        cyc_prev    = 1'b0;
        ipend_prev  = 1'b0;
        dpend_prev  = 1'b0;
        ended       = 1'b0;
        cyc_port    = PORT_I;
        // Data port counts as last served so instruction goes first
        last_port   = PORT_D;
        cycles_seen = 0;
        outst[PORT_I] = 1'b0;
        outst[PORT_D] = 1'b0;
        foreach (stim[i]) begin
            stim[i] = '1;
        end
        $readmemh("dv/bus_input.txt", stim);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim[num_lines*NCOL] != '1) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            fail_now("No requests were read from dv/bus_input.txt");
        end
        fork
            begin
                #((num_lines * 12 + 50) * CLK_PERIOD);
                fail_now("Timeout: the requests did not all complete in time");
            end
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        fork
            run_port(PORT_I);
            run_port(PORT_D);
        join
        repeat (2) @(negedge clk);
        if (cycles_seen != num_lines) begin
            fail_now($sformatf("Saw %0d bus cycles for %0d requests", cycles_seen, num_lines));
        end else if (UUT.bus_sva.fail_count != 0) begin
            fail_now("A Wishbone protocol assertion in the bound checker failed");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

// File: list.f
design/bus_cfg_pkg.sv
design/wb_types_pkg.sv
design/req_slot.sv
design/wb_master_ctrl.sv
design/resp_return.sv
design/litex_bus_wrapper.sv
dv/litex_bus_wrapper_sva.sv
dv/litex_bus_wrapper_tb.sv
